// ==== rv_decode_pkg.sv ====
//--------------------------------------------------------------------
// shared opcodes, field layouts and control structs of the RV32I
// decode stage, referenced by scoped names from every module
//--------------------------------------------------------------------
package rv_decode_pkg;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_fence  = 7'b0001111;
  localparam logic [6:0] op_system = 7'b1110011;

  // alu group, shared by register and immediate forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load/store width codes, stores use the signed ones only
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrc  = 3'b011;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;
  localparam logic [2:0] f3_csrrci = 3'b111;

  localparam logic [2:0] f3_fence   = 3'b000;
  localparam logic [2:0] f3_fence_i = 3'b001;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra

  localparam logic [31:0] word_ecall  = 32'h0000_0073;
  localparam logic [31:0] word_ebreak = 32'h0010_0073;
  localparam logic [31:0] word_mret   = 32'h3020_0073;

  //------------------------------------------------------------------
  // instruction word layouts
  //------------------------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    logic [31:0] word;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    u_fmt_t      u;
  } inst_word_u;

  // one bit per recognized instruction
  typedef struct packed {
    logic lui, auipc, jal, jalr;
    logic beq, bne, blt, bge, bltu, bgeu;
    logic lb, lh, lw, lbu, lhu;
    logic sb, sh, sw;
    logic addi, slti, sltiu, xori, ori, andi, slli, srli, srai;
    logic add, sub, sll, slt, sltu, xor_r, srl, sra, or_r, and_r;
    logic fence, fence_i;
    logic csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci;
    logic ecall, ebreak, mret;
    logic zero_word;
  } inst_class_t;

  typedef struct packed {
    logic       use_rs2;     // 0 selects imm as operand b
    logic       lui;
    logic       shift;
    logic       shift_right;
    logic       shift_logic;
    logic [1:0] cmp;         // 01 signed, 10 unsigned
    logic       and_op;
    logic       or_op;
    logic       xor_op;
    logic       add;
    logic       sub;
    logic       auipc;
  } alu_ctrl_t;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_beq  = 3'd1,
    br_bne  = 3'd2,
    br_blt  = 3'd3,
    br_bge  = 3'd4,
    br_bltu = 3'd5,
    br_bgeu = 3'd6
  } br_type_e;

  typedef struct packed {
    logic [1:0] op;   // 01 load, 10 store
    logic [1:0] size;
    logic       is_unsigned;
  } lsu_ctrl_t;

  typedef struct packed {
    logic        we;
    logic        set;
    logic        clear;
    logic        imm_en;
    logic [11:0] idx;
    logic [31:0] zimm;
  } csr_ctrl_t;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        gpr_we;
    logic [31:0] imm;
    alu_ctrl_t   alu;
    br_type_e    br;
    lsu_ctrl_t   lsu;
    logic        jal;
    logic        jalr;
    csr_ctrl_t   csr;
    logic        ecall;
    logic        ebreak;
    logic        mret;
    logic        illegal;
  } decode_out_t;

endpackage

// ==== inst_classify.sv ====
//--------------------------------------------------------------------
// first decode level, one class bit per RV32I instruction
//--------------------------------------------------------------------
`timescale 1ns/1ns

module inst_classify (
  input  rv_decode_pkg::inst_word_u  inst,
  output rv_decode_pkg::inst_class_t cls
);

  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       is_branch;
  logic       is_load;
  logic       is_store;
  logic       is_imm;
  logic       is_reg;
  logic       is_fence;
  logic       is_system;

  assign opc = inst.r.opcode;
  assign f3  = inst.r.funct3;
  assign f7  = inst.r.funct7;

  assign is_branch = (opc == rv_decode_pkg::op_branch);
  assign is_load   = (opc == rv_decode_pkg::op_load);
  assign is_store  = (opc == rv_decode_pkg::op_store);
  assign is_imm    = (opc == rv_decode_pkg::op_imm);
  assign is_reg    = (opc == rv_decode_pkg::op_reg);
  assign is_fence  = (opc == rv_decode_pkg::op_fence);
  assign is_system = (opc == rv_decode_pkg::op_system);

  always_comb begin
    cls.lui   = (opc == rv_decode_pkg::op_lui);
    cls.auipc = (opc == rv_decode_pkg::op_auipc);
    cls.jal   = (opc == rv_decode_pkg::op_jal);
    cls.jalr  = (opc == rv_decode_pkg::op_jalr); // funct3 not checked

    cls.beq  = is_branch && (f3 == rv_decode_pkg::f3_beq);
    cls.bne  = is_branch && (f3 == rv_decode_pkg::f3_bne);
    cls.blt  = is_branch && (f3 == rv_decode_pkg::f3_blt);
    cls.bge  = is_branch && (f3 == rv_decode_pkg::f3_bge);
    cls.bltu = is_branch && (f3 == rv_decode_pkg::f3_bltu);
    cls.bgeu = is_branch && (f3 == rv_decode_pkg::f3_bgeu);

    cls.lb  = is_load && (f3 == rv_decode_pkg::f3_byte);
    cls.lh  = is_load && (f3 == rv_decode_pkg::f3_half);
    cls.lw  = is_load && (f3 == rv_decode_pkg::f3_word);
    cls.lbu = is_load && (f3 == rv_decode_pkg::f3_byte_u);
    cls.lhu = is_load && (f3 == rv_decode_pkg::f3_half_u);

    cls.sb = is_store && (f3 == rv_decode_pkg::f3_byte);
    cls.sh = is_store && (f3 == rv_decode_pkg::f3_half);
    cls.sw = is_store && (f3 == rv_decode_pkg::f3_word);

    // immediate alu, shifts split on bit 30 only
    cls.addi  = is_imm && (f3 == rv_decode_pkg::f3_add_sub);
    cls.slti  = is_imm && (f3 == rv_decode_pkg::f3_slt);
    cls.sltiu = is_imm && (f3 == rv_decode_pkg::f3_sltu);
    cls.xori  = is_imm && (f3 == rv_decode_pkg::f3_xor);
    cls.ori   = is_imm && (f3 == rv_decode_pkg::f3_or);
    cls.andi  = is_imm && (f3 == rv_decode_pkg::f3_and);
    cls.slli  = is_imm && (f3 == rv_decode_pkg::f3_sll);
    cls.srli  = is_imm && (f3 == rv_decode_pkg::f3_srl_sra) && !inst.word[30];
    cls.srai  = is_imm && (f3 == rv_decode_pkg::f3_srl_sra) && inst.word[30];

    // register alu, funct7 checked on add/sub and srl/sra
    cls.add   = is_reg && (f3 == rv_decode_pkg::f3_add_sub) && (f7 == rv_decode_pkg::f7_base);
    cls.sub   = is_reg && (f3 == rv_decode_pkg::f3_add_sub) && (f7 == rv_decode_pkg::f7_alt);
    cls.sll   = is_reg && (f3 == rv_decode_pkg::f3_sll);
    cls.slt   = is_reg && (f3 == rv_decode_pkg::f3_slt);
    cls.sltu  = is_reg && (f3 == rv_decode_pkg::f3_sltu);
    cls.xor_r = is_reg && (f3 == rv_decode_pkg::f3_xor);
    cls.srl   = is_reg && (f3 == rv_decode_pkg::f3_srl_sra) && (f7 == rv_decode_pkg::f7_base);
    cls.sra   = is_reg && (f3 == rv_decode_pkg::f3_srl_sra) && (f7 == rv_decode_pkg::f7_alt);
    cls.or_r  = is_reg && (f3 == rv_decode_pkg::f3_or);
    cls.and_r = is_reg && (f3 == rv_decode_pkg::f3_and);

    cls.fence   = is_fence && (f3 == rv_decode_pkg::f3_fence);
    cls.fence_i = is_fence && (f3 == rv_decode_pkg::f3_fence_i);

    cls.csrrw  = is_system && (f3 == rv_decode_pkg::f3_csrrw);
    cls.csrrs  = is_system && (f3 == rv_decode_pkg::f3_csrrs);
    cls.csrrc  = is_system && (f3 == rv_decode_pkg::f3_csrrc);
    cls.csrrwi = is_system && (f3 == rv_decode_pkg::f3_csrrwi);
    cls.csrrsi = is_system && (f3 == rv_decode_pkg::f3_csrrsi);
    cls.csrrci = is_system && (f3 == rv_decode_pkg::f3_csrrci);

    // privileged words only match exactly
    cls.ecall  = (inst.word == rv_decode_pkg::word_ecall);
    cls.ebreak = (inst.word == rv_decode_pkg::word_ebreak);
    cls.mret   = (inst.word == rv_decode_pkg::word_mret);

    cls.zero_word = (inst.word == 32'h0);
  end

endmodule

// ==== imm_gen.sv ====
//--------------------------------------------------------------------
// immediate generator, picks the field layout from the class bits
//--------------------------------------------------------------------
`timescale 1ns/1ns

module imm_gen (
  input  rv_decode_pkg::inst_word_u  inst,
  input  rv_decode_pkg::inst_class_t cls,
  output logic [31:0]                imm
);

  logic i_fmt;
  logic s_fmt;
  logic b_fmt;
  logic u_fmt;

  // 12-bit sign-extended users
  assign i_fmt = cls.addi | cls.slti | cls.sltiu | cls.xori | cls.ori | cls.andi
               | cls.slli | cls.srli
               | cls.lb | cls.lh | cls.lw | cls.lbu | cls.lhu
               | cls.jalr;
  assign s_fmt = cls.sb | cls.sh | cls.sw;
  assign b_fmt = cls.beq | cls.bne | cls.blt | cls.bge | cls.bltu | cls.bgeu;
  assign u_fmt = cls.lui | cls.auipc;

  always_comb begin
    if (i_fmt) begin
      imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    end else if (cls.srai) begin
      // shamt only, funct7 bits are not part of the value
      imm = {{27{inst.word[31]}}, inst.r.rs2};
    end else if (s_fmt) begin
      imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    end else if (b_fmt) begin
      imm = {{20{inst.word[31]}}, inst.word[7], inst.word[30:25], inst.word[11:8], 1'b0};
    end else if (cls.jal) begin
      imm = {{12{inst.word[31]}}, inst.word[19:12], inst.word[20], inst.word[30:21], 1'b0};
    end else if (u_fmt) begin
      imm = {inst.u.imm20, 12'h000};
    end else begin
      imm = 32'h0; // no immediate
    end
  end

endmodule

// ==== ctrl_gen.sv ====
//--------------------------------------------------------------------
// control generator, folds class bits into the decoded result
// feeding alu, branch unit, lsu, csr file and gpr write port
//--------------------------------------------------------------------
`timescale 1ns/1ns

module ctrl_gen (
  input  rv_decode_pkg::inst_word_u  inst,
  input  rv_decode_pkg::inst_class_t cls,
  input  logic [31:0]                imm,
  output rv_decode_pkg::decode_out_t dec
);

  rv_decode_pkg::alu_ctrl_t alu;
  rv_decode_pkg::br_type_e  br;
  rv_decode_pkg::lsu_ctrl_t lsu;
  rv_decode_pkg::csr_ctrl_t csr;
  logic                     is_load;
  logic                     is_store;
  logic                     is_csr;
  logic                     gpr_we;
  logic                     illegal;

  assign is_load  = cls.lb | cls.lh | cls.lw | cls.lbu | cls.lhu;
  assign is_store = cls.sb | cls.sh | cls.sw;
  assign is_csr   = cls.csrrw | cls.csrrs | cls.csrrc | cls.csrrwi | cls.csrrsi | cls.csrrci;

  //------------------------------------------------------------------
  // alu control
  //------------------------------------------------------------------
  always_comb begin
    alu.use_rs2     = !(cls.addi | cls.slti | cls.sltiu | cls.xori | cls.ori | cls.andi
                      | cls.slli | cls.srli | cls.srai | cls.lui | cls.auipc
                      | is_load | is_store);
    alu.lui         = cls.lui;
    alu.shift       = cls.sll | cls.slli | cls.srl | cls.srli | cls.sra | cls.srai | cls.lui;
    alu.shift_right = cls.srl | cls.srli | cls.sra | cls.srai;
    alu.shift_logic = cls.sll | cls.slli | cls.srl | cls.srli | cls.lui;
    if (cls.slt | cls.slti) begin
      alu.cmp = 2'b01;
    end else if (cls.sltu | cls.sltiu) begin
      alu.cmp = 2'b10;
    end else begin
      alu.cmp = 2'b00;
    end
    alu.and_op = cls.and_r | cls.andi;
    alu.or_op  = cls.or_r | cls.ori;
    alu.xor_op = cls.xor_r | cls.xori;
    alu.add    = cls.add | cls.addi | is_load | is_store; // address calc too
    alu.sub    = cls.sub;
    alu.auipc  = cls.auipc;
  end

  always_comb begin
    if (cls.beq)       br = rv_decode_pkg::br_beq;
    else if (cls.bne)  br = rv_decode_pkg::br_bne;
    else if (cls.blt)  br = rv_decode_pkg::br_blt;
    else if (cls.bge)  br = rv_decode_pkg::br_bge;
    else if (cls.bltu) br = rv_decode_pkg::br_bltu;
    else if (cls.bgeu) br = rv_decode_pkg::br_bgeu;
    else               br = rv_decode_pkg::br_none;
  end

  // size and sign come straight from funct3
  always_comb begin
    lsu.op          = is_load ? 2'b01 : (is_store ? 2'b10 : 2'b00);
    lsu.size        = inst.r.funct3[1:0];
    lsu.is_unsigned = inst.r.funct3[2];
  end

  always_comb begin
    csr.we     = is_csr;
    csr.set    = cls.csrrs | cls.csrrsi;
    csr.clear  = cls.csrrc | cls.csrrci;
    csr.imm_en = cls.csrrwi | cls.csrrsi | cls.csrrci;
    csr.idx    = inst.i.imm12;
    csr.zimm   = {27'h0, inst.r.rs1}; // rs1 field as 5-bit uimm
  end

  //------------------------------------------------------------------
  // gpr write and illegal detect
  //------------------------------------------------------------------
  assign gpr_we = cls.addi | cls.slti | cls.sltiu | cls.xori | cls.ori | cls.andi
                | cls.slli | cls.srli | cls.srai
                | cls.add | cls.sub | cls.sll | cls.slt | cls.sltu | cls.xor_r
                | cls.srl | cls.sra | cls.or_r | cls.and_r
                | is_load | cls.jal | cls.jalr | cls.lui | cls.auipc | is_csr;

  // zero word passes as legal
  assign illegal = !(gpr_we | cls.jal | cls.jalr | (br != rv_decode_pkg::br_none) | is_store
                   | cls.fence | cls.fence_i | cls.ecall | cls.ebreak | cls.mret
                   | cls.zero_word);

  always_comb begin
    dec.rs1     = inst.r.rs1;
    dec.rs2     = inst.r.rs2;
    dec.rd      = inst.r.rd;
    dec.gpr_we  = gpr_we;
    dec.imm     = imm;
    dec.alu     = alu;
    dec.br      = br;
    dec.lsu     = lsu;
    dec.jal     = cls.jal;
    dec.jalr    = cls.jalr;
    dec.csr     = csr;
    dec.ecall   = cls.ecall;
    dec.ebreak  = cls.ebreak;
    dec.mret    = cls.mret;
    dec.illegal = illegal;
  end

endmodule

// ==== decode_pipe_reg.sv ====
//--------------------------------------------------------------------
// single-entry output register with valid/ready handshake
//--------------------------------------------------------------------
`timescale 1ns/1ns

module decode_pipe_reg (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  rv_decode_pkg::decode_out_t din,
  output logic                       out_valid,
  input  logic                       out_ready,
  output rv_decode_pkg::decode_out_t dout
);

  // slot frees up when empty or draining this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dout <= din;
    end
  end

endmodule

// ==== rv_decode_top.sv ====
//--------------------------------------------------------------------
// decode stage top, combinational decode into one output register
//--------------------------------------------------------------------
`timescale 1ns/1ns

module rv_decode_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rv_decode_pkg::inst_word_u  inst,
  input  logic                       in_valid,
  output logic                       in_ready,
  output logic                       out_valid,
  input  logic                       out_ready,
  output rv_decode_pkg::decode_out_t dout
);

  rv_decode_pkg::inst_class_t cls;
  rv_decode_pkg::decode_out_t dec;
  logic [31:0]                imm;

  inst_classify inst_classify_i (
    .inst (inst),
    .cls  (cls)
  );

  imm_gen imm_gen_i (
    .inst (inst),
    .cls  (cls),
    .imm  (imm)
  );

  ctrl_gen ctrl_gen_i (
    .inst (inst),
    .cls  (cls),
    .imm  (imm),
    .dec  (dec)
  );

  decode_pipe_reg decode_pipe_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .din       (dec),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .dout      (dout)
  );

endmodule

// ==== tb_rv_decode_assert.sv ====
//--------------------------------------------------------------------
// handshake and output checks, bound into the decode top level
//--------------------------------------------------------------------
`timescale 1ns/1ns

module tb_rv_decode_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       out_valid,
  input logic                       out_ready,
  input rv_decode_pkg::decode_out_t dout
);

  // output register empty while in reset
  reset_empty: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while rst_n is low");

  // stalled result holds until taken
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(dout)))
    else $error("output changed while stalled");

  illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !(dout.illegal && dout.gpr_we))
    else $error("illegal instruction with gpr write enabled");

endmodule

bind rv_decode_top tb_rv_decode_assert tb_rv_decode_assert_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .dout      (dout)
);

// ==== tb_rv_decode.sv ====
//--------------------------------------------------------------------
// table-driven testbench for the decode stage with random output stalls
// built as the simulation top from the file list
//--------------------------------------------------------------------
`timescale 1ns/1ns

module tb_rv_decode;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] imm;
    logic [12:0] alu;
    logic [2:0]  br;
    logic [4:0]  lsu;
    logic [3:0]  csr;     // we, set, clear, imm_en
    logic [4:0]  sys;     // jal, jalr, ecall, ebreak, mret
    logic        gpr_we;
    logic        illegal;
  } vec_t;

  logic                       clk;
  logic                       rst_n;
  rv_decode_pkg::inst_word_u  inst;
  logic                       in_valid;
  logic                       in_ready;
  logic                       out_valid;
  logic                       out_ready;
  rv_decode_pkg::decode_out_t dout;

  vec_t  vecs[$];
  string names[$];
  int    sent_q[$];     // table index of each accepted word
  int    seed = 34;
  int    nvec = 0;
  int    n_acc = 0;
  int    n_done = 0;
  int    n_ok = 0;
  int    n_bad = 0;
  int    n_err = 0;

  rv_decode_top rv_decode_top_i (.*);

  always #10 clk = ~clk;

  // sink stalls roughly one cycle in four
  always @(negedge clk) out_ready = ($random(seed) & 3) != 0;

  task automatic add_vec(input string name, input logic [31:0] word, input logic [31:0] imm,
                         input logic [12:0] alu, input logic [2:0] br, input logic [4:0] lsu,
                         input logic [3:0] csr, input logic [4:0] sys, input logic gpr_we,
                         input logic illegal);
    names.push_back(name);
    vecs.push_back({word, imm, alu, br, lsu, csr, sys, gpr_we, illegal});
  endtask

  //------------------------------------------------------------------
  // alu column groups use_rs2 lui shift shift_right shift_logic
  // then cmp then and or xor add sub auipc
  // lsu column groups op then size then unsigned
  //------------------------------------------------------------------
  task automatic load_table();
    add_vec("addi_neg", 'hFFB10093, 'hFFFFFFFB, 'b00000_00_000100, 0, 'b00_00_0, 0, 0, 1, 0);
    add_vec("srai",     'h40725193, 'h00000007, 'b00110_00_000000, 0, 'b00_01_1, 0, 0, 1, 0);
    add_vec("sw_neg",   'hFE532C23, 'hFFFFFFF8, 'b00000_00_000100, 0, 'b10_10_0, 0, 0, 0, 0);
    add_vec("beq_back", 'hFE2088E3, 'hFFFFFFF0, 'b10000_00_000000, 1, 'b00_00_0, 0, 0, 0, 0);
    add_vec("jal_back", 'hFFDFF0EF, 'hFFFFFFFC, 'b10000_00_000000, 0, 'b00_11_1, 0, 'b10000, 1, 0);
    add_vec("lui",      'h123452B7, 'h12345000, 'b01101_00_000000, 0, 'b00_01_1, 0, 0, 1, 0);
    add_vec("add",      'h002081B3, 'h00000000, 'b10000_00_000100, 0, 'b00_00_0, 0, 0, 1, 0);
    add_vec("sub",      'h402081B3, 'h00000000, 'b10000_00_000010, 0, 'b00_00_0, 0, 0, 1, 0);
    add_vec("slt",      'h0020A1B3, 'h00000000, 'b10000_01_000000, 0, 'b00_10_0, 0, 0, 1, 0);
    add_vec("sltiu",    'h0010B193, 'h00000001, 'b00000_10_000000, 0, 'b00_11_0, 0, 0, 1, 0);
    add_vec("xori",     'hFFF0C193, 'hFFFFFFFF, 'b00000_00_001000, 0, 'b00_00_1, 0, 0, 1, 0);
    add_vec("srl",      'h0020D1B3, 'h00000000, 'b10111_00_000000, 0, 'b00_01_1, 0, 0, 1, 0);
    add_vec("sra",      'h4020D1B3, 'h00000000, 'b10110_00_000000, 0, 'b00_01_1, 0, 0, 1, 0);
    add_vec("slli",     'h00409193, 'h00000004, 'b00101_00_000000, 0, 'b00_01_0, 0, 0, 1, 0);
    add_vec("auipc",    'h00001297, 'h00001000, 'b00000_00_000001, 0, 'b00_01_0, 0, 0, 1, 0);
    add_vec("bne",      'h00209463, 'h00000008, 'b10000_00_000000, 2, 'b00_01_0, 0, 0, 0, 0);
    add_vec("blt",      'h0020C463, 'h00000008, 'b10000_00_000000, 3, 'b00_00_1, 0, 0, 0, 0);
    add_vec("bge",      'h0020D463, 'h00000008, 'b10000_00_000000, 4, 'b00_01_1, 0, 0, 0, 0);
    add_vec("bltu",     'h0020E463, 'h00000008, 'b10000_00_000000, 5, 'b00_10_1, 0, 0, 0, 0);
    add_vec("bgeu",     'h0020F463, 'h00000008, 'b10000_00_000000, 6, 'b00_11_1, 0, 0, 0, 0);
    add_vec("jalr",     'h00C100E7, 'h0000000C, 'b10000_00_000000, 0, 'b00_00_0, 0, 'b01000, 1, 0);
    add_vec("lw",       'h0040A283, 'h00000004, 'b00000_00_000100, 0, 'b01_10_0, 0, 0, 1, 0);
    add_vec("lbu_neg",  'hFFF0C283, 'hFFFFFFFF, 'b00000_00_000100, 0, 'b01_00_1, 0, 0, 1, 0);
    add_vec("lh",       'h00209283, 'h00000002, 'b00000_00_000100, 0, 'b01_01_0, 0, 0, 1, 0);
    add_vec("sb",       'h005300A3, 'h00000001, 'b00000_00_000100, 0, 'b10_00_0, 0, 0, 0, 0);
    add_vec("sh",       'h00531323, 'h00000006, 'b00000_00_000100, 0, 'b10_01_0, 0, 0, 0, 0);
    add_vec("csrrs",    'h3000A2F3, 'h00000000, 'b10000_00_000000, 0, 'b00_10_0, 'b1100, 0, 1, 0);
    add_vec("csrrci",   'h3411F2F3, 'h00000000, 'b10000_00_000000, 0, 'b00_11_1, 'b1011, 0, 1, 0);
    add_vec("ecall",    'h00000073, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 'b00100, 0, 0);
    add_vec("ebreak",   'h00100073, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 'b00010, 0, 0);
    add_vec("mret",     'h30200073, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 'b00001, 0, 0);
    add_vec("bad_op",   'h0000007F, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 0, 0, 1);
    add_vec("bad_f7",   'h022081B3, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 0, 0, 1);
    add_vec("zero",     'h00000000, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 0, 0, 0);
    add_vec("fence",    'h0FF0000F, 'h00000000, 'b10000_00_000000, 0, 'b00_00_0, 0, 0, 0, 0);
    add_vec("fence_i",  'h0000100F, 'h00000000, 'b10000_00_000000, 0, 'b00_01_0, 0, 0, 0, 0);
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("MISMATCH %s %s expected %0h actual %0h", test, field, exp, act);
    n_err++;
  endtask

  task automatic check_result(input int idx);
    vec_t  v;
    string nm;
    int    errs_before;
    v = vecs[idx];
    nm = names[idx];
    errs_before = n_err;
    if (dout.imm !== v.imm) report_mismatch(nm, "imm", 64'(v.imm), 64'(dout.imm));
    if (dout.alu !== v.alu) report_mismatch(nm, "alu", 64'(v.alu), 64'(dout.alu));
    if (dout.br !== v.br) report_mismatch(nm, "br", 64'(v.br), 64'(dout.br));
    if (dout.lsu !== v.lsu) report_mismatch(nm, "lsu", 64'(v.lsu), 64'(dout.lsu));
    if ({dout.csr.we, dout.csr.set, dout.csr.clear, dout.csr.imm_en} !== v.csr)
      report_mismatch(nm, "csr_flags", 64'(v.csr),
                      64'({dout.csr.we, dout.csr.set, dout.csr.clear, dout.csr.imm_en}));
    // csr index and zimm come straight from the word
    if (dout.csr.idx !== v.word[31:20])
      report_mismatch(nm, "csr_idx", 64'(v.word[31:20]), 64'(dout.csr.idx));
    if (dout.csr.zimm !== {27'h0, v.word[19:15]})
      report_mismatch(nm, "csr_zimm", 64'(v.word[19:15]), 64'(dout.csr.zimm));
    if ({dout.rs1, dout.rs2, dout.rd} !== {v.word[19:15], v.word[24:20], v.word[11:7]})
      report_mismatch(nm, "regs", 64'({v.word[19:15], v.word[24:20], v.word[11:7]}),
                      64'({dout.rs1, dout.rs2, dout.rd}));
    if ({dout.jal, dout.jalr, dout.ecall, dout.ebreak, dout.mret} !== v.sys)
      report_mismatch(nm, "sys", 64'(v.sys),
                      64'({dout.jal, dout.jalr, dout.ecall, dout.ebreak, dout.mret}));
    if (dout.gpr_we !== v.gpr_we) report_mismatch(nm, "gpr_we", 64'(v.gpr_we), 64'(dout.gpr_we));
    if (dout.illegal !== v.illegal)
      report_mismatch(nm, "illegal", 64'(v.illegal), 64'(dout.illegal));
    n_done++;
    if (n_err == errs_before) begin
      n_ok++;
      $display("test %0d %s ok", idx, nm);
    end else begin
      n_bad++;
      $display("test %0d %s has %0d wrong fields", idx, nm, n_err - errs_before);
    end
  endtask

  // handshakes sampled on the rising edge with the output side first
  always @(posedge clk) begin
    if (rst_n) begin
      // input side blocked only while a result is stalled
      if (in_ready !== !(out_valid && !out_ready)) begin
        $display("in_ready is wrong for the current stall state");
        n_err++;
      end
      if (out_valid && out_ready) begin
        if (sent_q.size() == 0) begin
          $display("decode result came out with no instruction pending");
          n_err++;
        end else begin
          check_result(sent_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        sent_q.push_back(n_acc);
        n_acc++;
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    inst = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    load_table();
    nvec = vecs.size();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < nvec; i++) begin
      inst = vecs[i].word;
      in_valid = 1'b1;
      @(negedge clk);
      while (n_acc <= i) @(negedge clk); // held until accepted
    end
    in_valid = 1'b0;
    inst = '0;
    while (n_done < nvec) @(negedge clk);
    $display("%0d of %0d tests checked, %0d ok, %0d wrong, %0d errors",
             n_done, nvec, n_ok, n_bad, n_err);
    if (n_err == 0 && n_bad == 0 && n_done == nvec) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog allows 20 cycles per table entry
  initial begin
    wait (nvec != 0);
    #(nvec * 20 * 20);
    $display("timeout, only %0d of %0d decode results arrived", n_done, nvec);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== rv_decode.f ====
rv_decode_pkg.sv
inst_classify.sv
imm_gen.sv
ctrl_gen.sv
decode_pipe_reg.sv
rv_decode_top.sv
tb_rv_decode_assert.sv
tb_rv_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the decode stage testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module tb_rv_decode \
  -f rv_decode.f -o tb_rv_decode
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_rv_decode 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# result decided by the pass line in the output
if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
